/* rtl/rf_pkg.sv */
// Data word, physical register index and ALU opcode types, writeback lane count
`default_nettype none

package rf_pkg;

    // Integer datapath width
    typedef logic [63:0] xlen_t;

    // Physical register index, room for up to 64 entries
    typedef logic [5:0] phreg_t;

    // Writeback lanes into the register file
    // Lane 0 is the ALU result, lane 1 the load result
    localparam int NUM_WB = 2;

    // ALU operations carried from issue to execute
    typedef enum logic [2:0] {
        OP_ADD = 3'd0, // a + b
        OP_SUB = 3'd1, // a - b
        OP_AND = 3'd2, // Bitwise
        OP_OR  = 3'd3, // Bitwise
        OP_XOR = 3'd4, // Bitwise
        OP_SLL = 3'd5, // a << b[5:0]
        OP_SLT = 3'd6  // Signed a < b, result is 1 or 0
    } alu_op_e;

endpackage

`default_nettype wire

/* rtl/wb_if.sv */
// Writeback lane bundle with producer and register file modports
`timescale 1ns/1ps
`default_nettype none

interface wb_if;
    import rf_pkg::*;

    // One enable, destination and data word per lane
    logic   [NUM_WB-1:0] we;
    phreg_t [NUM_WB-1:0] addr;
    xlen_t  [NUM_WB-1:0] data;

    // ALU/load stage side, drives every lane
    modport prod (
        output we,
        output addr,
        output data
    );

    // Register file side, writes at the clock edge and bypasses in the same cycle
    modport file (
        input we,
        input addr,
        input data
    );

endinterface

`default_nettype wire

/* rtl/regfile.sv */
// Physical register file with two writeback lanes, two read ports, bypass and zero register
`timescale 1ns/1ps
`default_nettype none

module regfile #(
    parameter int NUM_PHREGS = 64               // Legal range 2 to 64
) (
    input  logic           clk_i,
    wb_if.file             wb,                  // Writeback lanes
    input  rf_pkg::phreg_t read_addr1_i,
    input  rf_pkg::phreg_t read_addr2_i,
    output rf_pkg::xlen_t  read_data1_o,
    output rf_pkg::xlen_t  read_data2_o
);
    import rf_pkg::*;

    localparam int NUM_RD = 2;                  // Read ports

    // Register 0 is hardwired, so storage starts at 1
    xlen_t mem [1:NUM_PHREGS-1];

    // Read ports folded into arrays so one loop serves both
    phreg_t            raddr    [NUM_RD];
    xlen_t             rdata    [NUM_RD];
    logic [NUM_WB-1:0] hit      [NUM_RD];       // Lane matches port address
    xlen_t             byp_data [NUM_RD];       // OR of all matching lane data

    assign raddr[0]     = read_addr1_i;
    assign raddr[1]     = read_addr2_i;
    assign read_data1_o = rdata[0];
    assign read_data2_o = rdata[1];

    // Combinational read with same-cycle forwarding
    always_comb begin
        for (int p = 0; p < NUM_RD; p++) begin
            byp_data[p] = '0;
            for (int l = 0; l < NUM_WB; l++) begin
                // Register 0 never hits, it must stay zero even while written
                hit[p][l] = wb.we[l] && (wb.addr[l] == raddr[p]) && (raddr[p] != '0);
                byp_data[p] = byp_data[p] | ({$bits(xlen_t){hit[p][l]}} & wb.data[l]);
            end

            if (raddr[p] == '0) begin
                rdata[p] = '0;                  // Zero register
            end else if (|hit[p]) begin
                rdata[p] = byp_data[p];         // Write in flight wins over stored value
            end else begin
                rdata[p] = mem[raddr[p]];
            end
        end
    end

    // Clocked writes, one per enabled lane
    // Two lanes on the same register is illegal, last lane would win here
    always_ff @(posedge clk_i) begin
        for (int l = 0; l < NUM_WB; l++) begin
            if (wb.we[l] && (wb.addr[l] != '0)) begin
                mem[wb.addr[l]] <= wb.data[l];
            end
        end
    end

endmodule

`default_nettype wire

/* rtl/operand_read.sv */
// Operand read stage, drives file read addresses and registers the issued op
`timescale 1ns/1ps
`default_nettype none

module operand_read #(
    parameter int NUM_PHREGS = 64               // Bound for source index check
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    // Issue side
    input  logic            issue_valid_i,
    input  rf_pkg::alu_op_e issue_op_i,
    input  rf_pkg::phreg_t  issue_src1_i,
    input  rf_pkg::phreg_t  issue_src2_i,
    input  rf_pkg::phreg_t  issue_dst_i,
    // Register file read ports
    output rf_pkg::phreg_t  read_addr1_o,
    output rf_pkg::phreg_t  read_addr2_o,
    input  rf_pkg::xlen_t   read_data1_i,
    input  rf_pkg::xlen_t   read_data2_i,
    // Toward execute
    output logic            ex_valid_o,
    output rf_pkg::alu_op_e ex_op_o,
    output rf_pkg::phreg_t  ex_dst_o,
    output rf_pkg::xlen_t   ex_opnd1_o,
    output rf_pkg::xlen_t   ex_opnd2_o
);

    // Sources index the file directly, data returns in the issue cycle
    assign read_addr1_o = issue_src1_i;
    assign read_addr2_o = issue_src2_i;

    // Stage valid
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_valid_o <= 1'b0;
        end else begin
            ex_valid_o <= issue_valid_i;
        end
    end

    // Payload captured only on issue, held otherwise
    always_ff @(posedge clk_i) begin
        if (issue_valid_i) begin
            ex_op_o    <= issue_op_i;
            ex_dst_o   <= issue_dst_i;
            ex_opnd1_o <= read_data1_i;         // Already includes bypass
            ex_opnd2_o <= read_data2_i;
        end
    end

    // Sources beyond the file size would read unallocated storage
    always_ff @(posedge clk_i) begin
        if (rst_n_i && issue_valid_i) begin
            assert ((int'(issue_src1_i) < NUM_PHREGS) && (int'(issue_src2_i) < NUM_PHREGS))
                else $error("operand_read: source index out of range");
        end
    end

endmodule

`default_nettype wire

/* rtl/alu_writeback.sv */
// Execute and writeback stage, ALU result onto lane 0 and load result onto lane 1
`timescale 1ns/1ps
`default_nettype none

module alu_writeback (
    input  logic            clk_i,
    input  logic            rst_n_i,
    // Registered op from operand read
    input  logic            ex_valid_i,
    input  rf_pkg::alu_op_e ex_op_i,
    input  rf_pkg::phreg_t  ex_dst_i,
    input  rf_pkg::xlen_t   ex_opnd1_i,
    input  rf_pkg::xlen_t   ex_opnd2_i,
    // External load completion
    input  logic            load_valid_i,
    input  rf_pkg::phreg_t  load_dst_i,
    input  rf_pkg::xlen_t   load_data_i,
    // Writeback lanes into the file
    wb_if.prod              wb,
    // Result report, mirrors lane 0
    output logic            result_valid_o,
    output rf_pkg::phreg_t  result_dst_o,
    output rf_pkg::xlen_t   result_data_o
);
    import rf_pkg::*;

    localparam int LANE_ALU = 0;
    localparam int LANE_LD  = 1;

    xlen_t             alu_result;
    logic   [NUM_WB-1:0] lane_we_q;             // Control, reset
    phreg_t [NUM_WB-1:0] lane_addr_q;           // Payload, no reset
    xlen_t  [NUM_WB-1:0] lane_data_q;

    // ALU
    always_comb begin
        case (ex_op_i)
            OP_ADD:  alu_result = ex_opnd1_i + ex_opnd2_i;
            OP_SUB:  alu_result = ex_opnd1_i - ex_opnd2_i;
            OP_AND:  alu_result = ex_opnd1_i & ex_opnd2_i;
            OP_OR:   alu_result = ex_opnd1_i | ex_opnd2_i;
            OP_XOR:  alu_result = ex_opnd1_i ^ ex_opnd2_i;
            OP_SLL:  alu_result = ex_opnd1_i << ex_opnd2_i[5:0];  // Low 6 bits only
            OP_SLT:  alu_result = {63'b0, $signed(ex_opnd1_i) < $signed(ex_opnd2_i)};
            default: alu_result = '0;           // Unused encoding
        endcase
    end

    // Lane enables, one cycle after their strobes
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            lane_we_q <= '0;
        end else begin
            lane_we_q[LANE_ALU] <= ex_valid_i;
            lane_we_q[LANE_LD]  <= load_valid_i;
        end
    end

    // Lane payloads, loaded only with their strobes
    always_ff @(posedge clk_i) begin
        if (ex_valid_i) begin
            lane_addr_q[LANE_ALU] <= ex_dst_i;  // Register 0 kept, file drops it
            lane_data_q[LANE_ALU] <= alu_result;
        end
        if (load_valid_i) begin
            lane_addr_q[LANE_LD] <= load_dst_i;
            lane_data_q[LANE_LD] <= load_data_i;
        end
    end

    assign wb.we   = lane_we_q;
    assign wb.addr = lane_addr_q;
    assign wb.data = lane_data_q;

    assign result_valid_o = lane_we_q[LANE_ALU];
    assign result_dst_o   = lane_addr_q[LANE_ALU];
    assign result_data_o  = lane_data_q[LANE_ALU];

endmodule

`default_nettype wire

/* rtl/rf_core_top.sv */
// Top level of the register read and writeback slice, file, operand read and ALU stage
`timescale 1ns/1ps
`default_nettype none

module rf_core_top #(
    parameter int NUM_PHREGS = 64               // Physical registers, 2 to 64
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    // Issue
    input  logic            issue_valid_i,
    input  rf_pkg::alu_op_e issue_op_i,
    input  rf_pkg::phreg_t  issue_src1_i,
    input  rf_pkg::phreg_t  issue_src2_i,
    input  rf_pkg::phreg_t  issue_dst_i,
    // Load completion
    input  logic            load_valid_i,
    input  rf_pkg::phreg_t  load_dst_i,
    input  rf_pkg::xlen_t   load_data_i,
    // ALU result, two cycles after issue
    output logic            result_valid_o,
    output rf_pkg::phreg_t  result_dst_o,
    output rf_pkg::xlen_t   result_data_o
);
    import rf_pkg::*;

    // Read ports
    phreg_t  rd_addr1;
    phreg_t  rd_addr2;
    xlen_t   rd_data1;
    xlen_t   rd_data2;

    // Operand read to execute
    logic    ex_valid;
    alu_op_e ex_op;
    phreg_t  ex_dst;
    xlen_t   ex_opnd1;
    xlen_t   ex_opnd2;

    wb_if u_wb ();                              // Both writeback lanes

    regfile #(
        .NUM_PHREGS   (NUM_PHREGS)
    ) u_regfile (
        .clk_i        (clk_i),
        .wb           (u_wb.file),
        .read_addr1_i (rd_addr1),
        .read_addr2_i (rd_addr2),
        .read_data1_o (rd_data1),
        .read_data2_o (rd_data2)
    );

    operand_read #(
        .NUM_PHREGS    (NUM_PHREGS)
    ) u_operand_read (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .issue_valid_i (issue_valid_i),
        .issue_op_i    (issue_op_i),
        .issue_src1_i  (issue_src1_i),
        .issue_src2_i  (issue_src2_i),
        .issue_dst_i   (issue_dst_i),
        .read_addr1_o  (rd_addr1),
        .read_addr2_o  (rd_addr2),
        .read_data1_i  (rd_data1),
        .read_data2_i  (rd_data2),
        .ex_valid_o    (ex_valid),
        .ex_op_o       (ex_op),
        .ex_dst_o      (ex_dst),
        .ex_opnd1_o    (ex_opnd1),
        .ex_opnd2_o    (ex_opnd2)
    );

    alu_writeback u_alu_writeback (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .ex_valid_i     (ex_valid),
        .ex_op_i        (ex_op),
        .ex_dst_i       (ex_dst),
        .ex_opnd1_i     (ex_opnd1),
        .ex_opnd2_i     (ex_opnd2),
        .load_valid_i   (load_valid_i),
        .load_dst_i     (load_dst_i),
        .load_data_i    (load_data_i),
        .wb             (u_wb.prod),
        .result_valid_o (result_valid_o),
        .result_dst_o   (result_dst_o),
        .result_data_o  (result_data_o)
    );

endmodule

`default_nettype wire

/* test/rf_core_checker.sv */
// Concurrent assertions on the writeback lanes, lane enables in reset and result strobe timing
`timescale 1ns/1ps
`default_nettype none

module rf_core_checker (
    input  logic                                       clk_i,
    input  logic                                       rst_n_i,
    input  logic                                       ex_valid_i,     // Op leaving operand read
    input  logic           [rf_pkg::NUM_WB-1:0]        we_i,           // Lane enables
    input  rf_pkg::phreg_t [rf_pkg::NUM_WB-1:0]        addr_i,         // Lane destinations
    input  logic                                       result_valid_i
);

    // Two lanes on one nonzero register would leave the file contents undefined
    lane_addr_unique: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !(we_i[0] && we_i[1] && (addr_i[0] == addr_i[1]) && (addr_i[0] != '0)))
        else $error("both writeback lanes target the same nonzero register");

    // Execute to writeback is exactly one register stage
    result_follows_ex: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        result_valid_i == $past(ex_valid_i))
        else $error("result strobe does not follow ex valid by one cycle");

    // Nothing may write the file while reset is held
    quiet_in_reset: assert property (@(posedge clk_i)
        !rst_n_i |-> ((we_i == '0) && !result_valid_i))
        else $error("writeback lane enabled during reset");

endmodule

`default_nettype wire

/* test/tb_rf_core.sv */
// Testbench for rf_core_top with clock, reset, LFSR data, reference model and directed tests
`timescale 1ns/1ps
`default_nettype none

module tb_rf_core;
    import rf_pkg::*;

    localparam int NUM_PHREGS = 64;
    localparam int TIMEOUT    = 20;             // Cycles allowed for results to drain

    logic    clk_i = 1'b0;
    logic    rst_n_i;
    logic    issue_valid_i;
    alu_op_e issue_op_i;
    phreg_t  issue_src1_i;
    phreg_t  issue_src2_i;
    phreg_t  issue_dst_i;
    logic    load_valid_i;
    phreg_t  load_dst_i;
    xlen_t   load_data_i;
    logic    result_valid_o;
    phreg_t  result_dst_o;
    xlen_t   result_data_o;

    xlen_t       model [NUM_PHREGS];            // Architectural view of the file
    logic [31:0] lfsr = 32'hdd1c_0038;
    int          cyc_cnt = 0;                   // Negedges seen so far
    int          mismatches = 0;
    int          other_errs = 0;
    xlen_t       last_data;                     // Most recent result seen by the monitor
    phreg_t      exp_dst_q [$];                 // Expected results, issue order
    xlen_t       exp_data_q [$];
    int          exp_cyc_q [$];                 // Cycle stamp of each issue

    rf_core_top #(.NUM_PHREGS(NUM_PHREGS)) u_rf_core_top (.*);

    bind alu_writeback rf_core_checker u_rf_core_checker (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .ex_valid_i     (ex_valid_i),
        .we_i           (lane_we_q),
        .addr_i         (lane_addr_q),
        .result_valid_i (result_valid_o)
    );

    always #4 clk_i = ~clk_i;                   // 8 ns period

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output xlen_t w);
        w = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);             // One step per bit
            w    = {w[62:0], lfsr[0]};
        end
    endtask

    task automatic rand_reg(output phreg_t r);
        xlen_t w;
        rand_bits(6, w);
        r = phreg_t'(w[5:0]);
        if (r == '0) r = 6'd1;                  // Keep clear of the zero register
    endtask

    // Opcode semantics as stated for the package
    function automatic xlen_t ref_alu(input alu_op_e op, input xlen_t a, input xlen_t b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[5:0];
            OP_SLT:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            default: return '0;
        endcase
    endfunction

    task automatic issue_op(input alu_op_e op, input phreg_t s1, input phreg_t s2,
                            input phreg_t dst);
        xlen_t res;
        @(posedge clk_i);
        issue_valid_i <= 1'b1;
        issue_op_i    <= op;
        issue_src1_i  <= s1;
        issue_src2_i  <= s2;
        issue_dst_i   <= dst;
        load_valid_i  <= 1'b0;
        res = ref_alu(op, model[s1], model[s2]);
        exp_dst_q.push_back(dst);
        exp_data_q.push_back(res);
        exp_cyc_q.push_back(cyc_cnt + 1);       // Negedge of the issue cycle
        if (dst != '0) model[dst] = res;        // Visible to ops two or more cycles later
    endtask

    task automatic do_load(input phreg_t dst, input xlen_t data);
        @(posedge clk_i);
        load_valid_i  <= 1'b1;
        load_dst_i    <= dst;
        load_data_i   <= data;
        issue_valid_i <= 1'b0;
        if (dst != '0) model[dst] = data;       // Readable from the next cycle by bypass
    endtask

    task automatic idle_inputs();
        @(posedge clk_i);
        issue_valid_i <= 1'b0;
        load_valid_i  <= 1'b0;
    endtask

    task automatic drain_results();
        int t;
        t = 0;
        while ((exp_dst_q.size() != 0) && (t < TIMEOUT)) begin
            @(posedge clk_i);
            t++;
        end
        assert (exp_dst_q.size() == 0) else begin
            other_errs++;
            $display("Error at %0t: timed out waiting for result_valid_o", $time);
        end
        exp_dst_q.delete();
        exp_data_q.delete();
        exp_cyc_q.delete();
    endtask

    task automatic do_op(input alu_op_e op, input phreg_t s1, input phreg_t s2,
                         input phreg_t dst, output xlen_t res);
        issue_op(op, s1, s2, dst);
        idle_inputs();
        drain_results();
        res = last_data;
    endtask

    // Result monitor, samples away from the driving edge
    always @(negedge clk_i) begin
        cyc_cnt = cyc_cnt + 1;
        if (rst_n_i && result_valid_o) begin
            assert (exp_dst_q.size() != 0) else begin
                other_errs++;
                $display("Error at %0t: result strobe with no op in flight", $time);
            end
            if (exp_dst_q.size() != 0) begin
                assert (result_dst_o == exp_dst_q[0]) else begin
                    mismatches++;
                    $display("Mismatch at %0t: result_dst_o expected %0d got %0d",
                             $time, exp_dst_q[0], result_dst_o);
                end
                assert (result_data_o == exp_data_q[0]) else begin
                    mismatches++;
                    $display("Mismatch at %0t: result_data_o expected %h got %h",
                             $time, exp_data_q[0], result_data_o);
                end
                assert (cyc_cnt - exp_cyc_q[0] == 2) else begin
                    mismatches++;
                    $display("Mismatch at %0t: result_valid_o latency expected 2 got %0d",
                             $time, cyc_cnt - exp_cyc_q[0]);
                end
                last_data = result_data_o;
                void'(exp_dst_q.pop_front());
                void'(exp_data_q.pop_front());
                void'(exp_cyc_q.pop_front());
            end
        end
    end

    // Loaded value read back through OR with register 0, issued in the bypass cycle
    task automatic load_readback();
        phreg_t r;
        xlen_t  d;
        xlen_t  res;
        for (int i = 0; i < 6; i++) begin
            rand_reg(r);
            rand_bits(64, d);
            do_load(r, d);
            do_op(OP_OR, r, 6'd0, 6'd40, res);
            assert (res == d) else begin
                mismatches++;
                $display("Mismatch at %0t: result_data_o expected %h got %h", $time, d, res);
            end
        end
    endtask

    // Every opcode in both operand orders, two rounds of fresh data
    task automatic all_opcodes();
        xlen_t a;
        xlen_t b;
        xlen_t res;
        for (int round = 0; round < 2; round++) begin
            rand_bits(64, a);
            rand_bits(64, b);
            if (round == 0) begin
                a[63] = 1'b1;                   // Opposite signs so SLT must compare signed
                b[63] = 1'b0;
            end
            do_load(6'd10, a);
            do_load(6'd11, b);
            for (int k = 0; k <= 6; k++) begin
                do_op(alu_op_e'(k), 6'd10, 6'd11, 6'd12, res);
                do_op(alu_op_e'(k), 6'd11, 6'd10, 6'd12, res);
            end
        end
    endtask

    task automatic zero_register();
        xlen_t d;
        xlen_t res;
        rand_bits(64, d);
        do_load(6'd0, d);
        do_op(OP_ADD, 6'd0, 6'd0, 6'd13, res);  // Read while lane 1 writes register 0
        do_op(OP_ADD, 6'd10, 6'd11, 6'd0, res); // Strobe still carries the sum
        do_op(OP_ADD, 6'd0, 6'd0, 6'd13, res);
    endtask

    // Consumer issued two cycles after its producer, lane 0 in flight
    task automatic bypass_paths();
        issue_op(OP_ADD, 6'd10, 6'd11, 6'd20);
        idle_inputs();
        issue_op(OP_XOR, 6'd20, 6'd10, 6'd21);
        idle_inputs();
        drain_results();
    endtask

    task automatic dual_lane_and_back_to_back();
        xlen_t d;
        xlen_t res;
        rand_bits(64, d);
        issue_op(OP_SUB, 6'd10, 6'd11, 6'd22);
        do_load(6'd23, d);                      // Lane 1 lands with lane 0
        idle_inputs();
        drain_results();
        do_op(OP_OR, 6'd22, 6'd0, 6'd24, res);
        do_op(OP_OR, 6'd23, 6'd0, 6'd25, res);
        issue_op(OP_ADD, 6'd10, 6'd11, 6'd26);  // Independent ops, one per cycle
        issue_op(OP_SUB, 6'd10, 6'd11, 6'd27);
        issue_op(OP_AND, 6'd24, 6'd25, 6'd28);
        issue_op(OP_XOR, 6'd24, 6'd11, 6'd29);
        idle_inputs();
        drain_results();
    endtask

    initial begin
        rst_n_i       = 1'b0;
        issue_valid_i = 1'b0;
        issue_op_i    = OP_ADD;
        issue_src1_i  = '0;
        issue_src2_i  = '0;
        issue_dst_i   = '0;
        load_valid_i  = 1'b0;
        load_dst_i    = '0;
        load_data_i   = '0;
        for (int i = 0; i < NUM_PHREGS; i++) model[i] = '0;
        repeat (8) @(posedge clk_i);
        rst_n_i <= 1'b1;
        load_readback();
        all_opcodes();
        zero_register();
        bypass_paths();
        dual_lane_and_back_to_back();
        repeat (2) @(posedge clk_i);
        $display("Errors: %0d mismatches, %0d other", mismatches, other_errs);
        if ((mismatches == 0) && (other_errs == 0)) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
rtl/rf_pkg.sv
rtl/wb_if.sv
rtl/regfile.sv
rtl/operand_read.sv
rtl/alu_writeback.sv
rtl/rf_core_top.sv
test/rf_core_checker.sv
test/tb_rf_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f vlog.f --top-module tb_rf_core -Mdir obj_dir

./obj_dir/Vtb_rf_core | tee sim.log

if grep -qF '*** PASSED ***' sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
